/* logic/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // opcodes as they arrive from the front end
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_SLTI,
        OP_SLTIU,
        OP_LUI,
        OP_AUIPC
    } inst_op_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLL  = 4'h5,
        ALU_SRL  = 4'h6,
        ALU_SRA  = 4'h7,
        ALU_SLT  = 4'h8,
        ALU_SLTU = 4'h9
    } alu_op_e;

    typedef struct packed {
        inst_op_e op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        word_t    pc;
    } issue_req_t;

    // alt_a stands in for rs1 and alt_b for rs2 when that source is unused
    typedef struct packed {
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     rd_write;
        reg_idx_t rs1;
        logic     use_rs1;
        reg_idx_t rs2;
        logic     use_rs2;
        word_t    alt_a;
        word_t    alt_b;
    } decoded_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } commit_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } complete_t;

    // a source is either a value or, while pending, waits on a tag carried alongside
    typedef struct packed {
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     src1_pend;
        word_t    src1;
        logic     src2_pend;
        word_t    src2;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* logic/issue_decode.sv */
`default_nettype none

module issue_decode #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  flush,
    input  logic                  issue_valid,
    input  rs_pkg::issue_req_t    issue_req,
    input  logic [TAG_WIDTH-1:0]  issue_tag,
    output logic                  dec_valid,
    output rs_pkg::decoded_t      dec,
    output logic [TAG_WIDTH-1:0]  dec_tag
);
    import rs_pkg::*;

    decoded_t dec_next;
    logic     is_reg_reg;
    logic     is_upper;

    // only the register-register forms read rs2
    assign is_reg_reg = issue_req.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                             OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    assign is_upper   = issue_req.op inside {OP_LUI, OP_AUIPC};

    always_comb begin
        dec_next.rd       = issue_req.rd;
        dec_next.rd_write = (issue_req.rd != '0);
        dec_next.rs1      = issue_req.rs1;
        dec_next.use_rs1  = !is_upper;
        dec_next.rs2      = issue_req.rs2;
        dec_next.use_rs2  = is_reg_reg;
        // LUI adds the immediate to zero, AUIPC adds it to the pc
        dec_next.alt_a    = (issue_req.op == OP_AUIPC) ? issue_req.pc : '0;
        dec_next.alt_b    = issue_req.imm;

        case (issue_req.op)
            OP_SUB:            dec_next.alu_op = ALU_SUB;
            OP_AND, OP_ANDI:   dec_next.alu_op = ALU_AND;
            OP_OR, OP_ORI:     dec_next.alu_op = ALU_OR;
            OP_XOR, OP_XORI:   dec_next.alu_op = ALU_XOR;
            OP_SLL, OP_SLLI:   dec_next.alu_op = ALU_SLL;
            OP_SRL, OP_SRLI:   dec_next.alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:   dec_next.alu_op = ALU_SRA;
            OP_SLT, OP_SLTI:   dec_next.alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU: dec_next.alu_op = ALU_SLTU;
            default:           dec_next.alu_op = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        dec     <= dec_next;
        dec_tag <= issue_tag;
    end

endmodule

`default_nettype wire

/* logic/operand_fetch.sv */
`default_nettype none

module operand_fetch #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  flush,
    input  logic                  dec_valid,
    input  rs_pkg::decoded_t      dec,
    input  logic [TAG_WIDTH-1:0]  dec_tag,
    input  logic                  commit_valid,
    input  rs_pkg::commit_t       commit,
    input  logic [TAG_WIDTH-1:0]  commit_tag,
    output logic                  fetch_valid,
    output rs_pkg::fetch_entry_t  fetch_entry,
    output logic [TAG_WIDTH-1:0]  fetch_src1_tag,
    output logic [TAG_WIDTH-1:0]  fetch_src2_tag,
    output logic [TAG_WIDTH-1:0]  fetch_tag
);
    import rs_pkg::*;

    word_t                regfile_q [32];
    logic [31:0]          pend_q;
    logic [TAG_WIDTH-1:0] rtag_q [32];

    reg_idx_t             src_idx  [2];
    logic                 src_use  [2];
    word_t                src_alt  [2];
    logic                 src_pend [2];
    word_t                src_val  [2];
    logic [TAG_WIDTH-1:0] src_tag  [2];

    assign src_idx[0] = dec.rs1;
    assign src_idx[1] = dec.rs2;
    assign src_use[0] = dec.use_rs1;
    assign src_use[1] = dec.use_rs2;
    assign src_alt[0] = dec.alt_a;
    assign src_alt[1] = dec.alt_b;

    // x0 is never renamed and never written, so it falls through as zero
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_pend[s] = 1'b0;
            src_tag[s]  = '0;
            src_val[s]  = src_alt[s];
            if (src_use[s]) begin
                if (!pend_q[src_idx[s]]) begin
                    src_val[s] = regfile_q[src_idx[s]];
                end else if (commit_valid && commit_tag == rtag_q[src_idx[s]]) begin
                    // the producer commits in this very cycle
                    src_val[s] = commit.value;
                end else begin
                    src_pend[s] = 1'b1;
                    src_tag[s]  = rtag_q[src_idx[s]];
                    src_val[s]  = '0;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int r = 0; r < 32; r++) begin
                regfile_q[r] <= '0;
                rtag_q[r]    <= '0;
            end
            pend_q <= '0;
        end else begin
            if (commit_valid && commit.rd != '0) begin
                regfile_q[commit.rd] <= commit.value;
                // a newer rename of the same register must stay in place
                if (pend_q[commit.rd] && rtag_q[commit.rd] == commit_tag) begin
                    pend_q[commit.rd] <= 1'b0;
                end
            end
            if (flush) begin
                pend_q <= '0;
            end else if (dec_valid && dec.rd_write) begin
                pend_q[dec.rd] <= 1'b1;
                rtag_q[dec.rd] <= dec_tag;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        fetch_entry.alu_op    <= dec.alu_op;
        fetch_entry.rd        <= dec.rd;
        fetch_entry.src1_pend <= src_pend[0];
        fetch_entry.src1      <= src_val[0];
        fetch_entry.src2_pend <= src_pend[1];
        fetch_entry.src2      <= src_val[1];
        fetch_src1_tag        <= src_tag[0];
        fetch_src2_tag        <= src_tag[1];
        fetch_tag             <= dec_tag;
    end

endmodule

`default_nettype wire

/* logic/station_array.sv */
`default_nettype none

module station_array #(
    parameter int TAG_WIDTH     = 4,
    parameter int STATION_DEPTH = 4
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  flush,
    input  logic                  fetch_valid,
    input  rs_pkg::fetch_entry_t  fetch_entry,
    input  logic [TAG_WIDTH-1:0]  fetch_src1_tag,
    input  logic [TAG_WIDTH-1:0]  fetch_src2_tag,
    input  logic [TAG_WIDTH-1:0]  fetch_tag,
    input  logic                  dec_valid,
    input  logic                  commit_valid,
    input  logic [TAG_WIDTH-1:0]  commit_tag,
    input  rs_pkg::word_t         commit_value,
    output logic                  issue_space,
    output logic                  disp_valid,
    output rs_pkg::alu_op_e       disp_alu_op,
    output rs_pkg::word_t         disp_a,
    output rs_pkg::word_t         disp_b,
    output rs_pkg::reg_idx_t      disp_rd,
    output logic [TAG_WIDTH-1:0]  disp_tag
);
    import rs_pkg::*;

    localparam int IDX_W = (STATION_DEPTH > 1) ? $clog2(STATION_DEPTH) : 1;
    // room for the occupied entries plus the two items in flight
    localparam int CNT_W = $clog2(STATION_DEPTH + 3);

    logic [STATION_DEPTH-1:0] valid_q;
    fetch_entry_t             ent_q  [STATION_DEPTH];
    logic [TAG_WIDTH-1:0]     q1_q   [STATION_DEPTH];
    logic [TAG_WIDTH-1:0]     q2_q   [STATION_DEPTH];
    logic [TAG_WIDTH-1:0]     tag_q  [STATION_DEPTH];

    fetch_entry_t             entry_in;
    logic [IDX_W-1:0]         sel_idx;
    logic [IDX_W-1:0]         free_idx;
    logic [CNT_W-1:0]         occ_cnt;

    function automatic logic tag_hit(input logic pend, input logic [TAG_WIDTH-1:0] q);
        return commit_valid && pend && (q == commit_tag);
    endfunction

    // an entry arriving from fetch can be woken by the commit of its own write cycle
    always_comb begin
        entry_in = fetch_entry;
        if (tag_hit(fetch_entry.src1_pend, fetch_src1_tag)) begin
            entry_in.src1      = commit_value;
            entry_in.src1_pend = 1'b0;
        end
        if (tag_hit(fetch_entry.src2_pend, fetch_src2_tag)) begin
            entry_in.src2      = commit_value;
            entry_in.src2_pend = 1'b0;
        end
    end

    // walking down from the top leaves the lowest matching index in place
    always_comb begin
        disp_valid = 1'b0;
        sel_idx    = '0;
        free_idx   = '0;
        occ_cnt    = '0;
        for (int i = STATION_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && !ent_q[i].src1_pend && !ent_q[i].src2_pend) begin
                disp_valid = 1'b1;
                sel_idx    = IDX_W'(i);
            end
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
            occ_cnt = occ_cnt + CNT_W'(valid_q[i]);
        end
    end

    assign issue_space = (occ_cnt + CNT_W'(dec_valid) + CNT_W'(fetch_valid))
                         < CNT_W'(STATION_DEPTH);

    assign disp_alu_op = ent_q[sel_idx].alu_op;
    assign disp_a      = ent_q[sel_idx].src1;
    assign disp_b      = ent_q[sel_idx].src2;
    assign disp_rd     = ent_q[sel_idx].rd;
    assign disp_tag    = tag_q[sel_idx];

    // the ALU never refuses, so a dispatched entry is freed at once
    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            valid_q <= '0;
        end else begin
            if (disp_valid) begin
                valid_q[sel_idx] <= 1'b0;
            end
            if (fetch_valid) begin
                valid_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < STATION_DEPTH; i++) begin
            if (valid_q[i] && tag_hit(ent_q[i].src1_pend, q1_q[i])) begin
                ent_q[i].src1      <= commit_value;
                ent_q[i].src1_pend <= 1'b0;
            end
            if (valid_q[i] && tag_hit(ent_q[i].src2_pend, q2_q[i])) begin
                ent_q[i].src2      <= commit_value;
                ent_q[i].src2_pend <= 1'b0;
            end
        end
        if (fetch_valid) begin
            ent_q[free_idx] <= entry_in;
            q1_q[free_idx]  <= fetch_src1_tag;
            q2_q[free_idx]  <= fetch_src2_tag;
            tag_q[free_idx] <= fetch_tag;
        end
    end

endmodule

`default_nettype wire

/* logic/alu_execute.sv */
`default_nettype none

module alu_execute #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  rs_pkg::alu_op_e       disp_alu_op,
    input  rs_pkg::word_t         disp_a,
    input  rs_pkg::word_t         disp_b,
    input  rs_pkg::reg_idx_t      disp_rd,
    input  logic [TAG_WIDTH-1:0]  disp_tag,
    output logic                  complete_valid,
    output rs_pkg::complete_t     complete,
    output logic [TAG_WIDTH-1:0]  complete_tag
);
    import rs_pkg::*;

    word_t    result;
    logic [4:0] shamt;

    assign shamt = disp_b[4:0];

    always_comb begin
        case (disp_alu_op)
            ALU_SUB:  result = disp_a - disp_b;
            ALU_AND:  result = disp_a & disp_b;
            ALU_OR:   result = disp_a | disp_b;
            ALU_XOR:  result = disp_a ^ disp_b;
            ALU_SLL:  result = disp_a << shamt;
            ALU_SRL:  result = disp_a >> shamt;
            ALU_SRA:  result = word_t'($signed(disp_a) >>> shamt);
            ALU_SLT:  result = {31'b0, $signed(disp_a) < $signed(disp_b)};
            ALU_SLTU: result = {31'b0, disp_a < disp_b};
            default:  result = disp_a + disp_b;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= disp_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        complete.rd    <= disp_rd;
        complete.value <= result;
        complete_tag   <= disp_tag;
    end

endmodule

`default_nettype wire

/* logic/rs_top.sv */
`default_nettype none

module rs_top #(
    parameter int TAG_WIDTH     = 4,
    parameter int STATION_DEPTH = 4
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  issue_valid,
    input  rs_pkg::issue_req_t    issue_req,
    input  logic [TAG_WIDTH-1:0]  issue_tag,
    input  logic                  commit_valid,
    input  rs_pkg::commit_t       commit,
    input  logic [TAG_WIDTH-1:0]  commit_tag,
    input  logic                  flush,
    output logic                  issue_space,
    output logic                  complete_valid,
    output rs_pkg::complete_t     complete,
    output logic [TAG_WIDTH-1:0]  complete_tag
);
    import rs_pkg::*;

    logic                 dec_valid;
    decoded_t             dec;
    logic [TAG_WIDTH-1:0] dec_tag;

    logic                 fetch_valid;
    fetch_entry_t         fetch_entry;
    logic [TAG_WIDTH-1:0] fetch_src1_tag;
    logic [TAG_WIDTH-1:0] fetch_src2_tag;
    logic [TAG_WIDTH-1:0] fetch_tag;

    logic                 disp_valid;
    alu_op_e              disp_alu_op;
    word_t                disp_a;
    word_t                disp_b;
    reg_idx_t             disp_rd;
    logic [TAG_WIDTH-1:0] disp_tag;

    issue_decode #(
        .TAG_WIDTH (TAG_WIDTH)
    ) decode_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_tag   (issue_tag),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .dec_tag     (dec_tag)
    );

    operand_fetch #(
        .TAG_WIDTH (TAG_WIDTH)
    ) fetch_i (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .flush          (flush),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .dec_tag        (dec_tag),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_tag     (commit_tag),
        .fetch_valid    (fetch_valid),
        .fetch_entry    (fetch_entry),
        .fetch_src1_tag (fetch_src1_tag),
        .fetch_src2_tag (fetch_src2_tag),
        .fetch_tag      (fetch_tag)
    );

    // the station also sees dec_valid so that issue_space counts items in flight
    station_array #(
        .TAG_WIDTH     (TAG_WIDTH),
        .STATION_DEPTH (STATION_DEPTH)
    ) station_i (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .flush          (flush),
        .fetch_valid    (fetch_valid),
        .fetch_entry    (fetch_entry),
        .fetch_src1_tag (fetch_src1_tag),
        .fetch_src2_tag (fetch_src2_tag),
        .fetch_tag      (fetch_tag),
        .dec_valid      (dec_valid),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_value   (commit.value),
        .issue_space    (issue_space),
        .disp_valid     (disp_valid),
        .disp_alu_op    (disp_alu_op),
        .disp_a         (disp_a),
        .disp_b         (disp_b),
        .disp_rd        (disp_rd),
        .disp_tag       (disp_tag)
    );

    alu_execute #(
        .TAG_WIDTH (TAG_WIDTH)
    ) alu_i (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .flush          (flush),
        .disp_valid     (disp_valid),
        .disp_alu_op    (disp_alu_op),
        .disp_a         (disp_a),
        .disp_b         (disp_b),
        .disp_rd        (disp_rd),
        .disp_tag       (disp_tag),
        .complete_valid (complete_valid),
        .complete       (complete),
        .complete_tag   (complete_tag)
    );

endmodule

`default_nettype wire

/* dv/rs_asserts.sv */
`default_nettype none

module rs_asserts #(
    parameter int TAG_WIDTH = 4
) (
    input logic                 clk_in,
    input logic                 rst_in,
    input logic                 flush,
    input logic                 issue_valid,
    input logic                 issue_space,
    input logic                 complete_valid,
    input rs_pkg::complete_t    complete,
    input logic [TAG_WIDTH-1:0] complete_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    // the front end may only issue while the station has room
    a_issue_space: assert property (@(posedge clk_in) disable iff (rst_in)
        issue_valid |-> issue_space)
        else $error("issue_valid high while issue_space is low");

    a_quiet_after_clear: assert property (@(posedge clk_in)
        (rst_in || flush) |=> !complete_valid)
        else $error("complete_valid high in the cycle after reset or flush");

    // everything qualified by complete_valid has to be known
    a_complete_known: assert property (@(posedge clk_in) disable iff (rst_in)
        complete_valid |-> !$isunknown({complete, complete_tag}))
        else $error("completion carries unknown bits");

endmodule

bind rs_top rs_asserts #(
    .TAG_WIDTH (TAG_WIDTH)
) asserts_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .flush          (flush),
    .issue_valid    (issue_valid),
    .issue_space    (issue_space),
    .complete_valid (complete_valid),
    .complete       (complete),
    .complete_tag   (complete_tag)
);

`default_nettype wire

/* dv/tb_top.sv */
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import rs_pkg::*;

    localparam int TAG_WIDTH     = 4;
    localparam int STATION_DEPTH = 4;
    localparam int NTAGS         = 1 << TAG_WIDTH;
    localparam int SINGLE_ROWS   = 25;
    localparam int WAIT_LIMIT    = 200;

    typedef struct packed {
        issue_req_t req;
        logic       hold;
        logic       flush;
    } row_t;

    logic                 clk_in;
    logic                 rst_in;
    logic                 issue_valid;
    issue_req_t           issue_req;
    logic [TAG_WIDTH-1:0] issue_tag;
    logic                 commit_valid;
    commit_t              commit;
    logic [TAG_WIDTH-1:0] commit_tag;
    logic                 flush;
    logic                 issue_space;
    logic                 complete_valid;
    complete_t            complete;
    logic [TAG_WIDTH-1:0] complete_tag;

    // stimulus table, register images and the reorder buffer, indexed by tag
    row_t      rows [$];
    string     row_names [$];
    word_t     spec_regs [32];
    word_t     arch_regs [32];
    complete_t exp_res [NTAGS];
    logic      done [NTAGS];
    logic      exact [NTAGS];
    int        issue_cycle [NTAGS];
    string     tag_name [NTAGS];
    int        head;
    int        tail;
    int        count;
    int        uncompleted;
    int        cycle;
    logic      hold_commits;
    logic      space_low_seen;

    rs_top #(
        .TAG_WIDTH     (TAG_WIDTH),
        .STATION_DEPTH (STATION_DEPTH)
    ) dut_i (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .issue_valid    (issue_valid),
        .issue_req      (issue_req),
        .issue_tag      (issue_tag),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_tag     (commit_tag),
        .flush          (flush),
        .issue_space    (issue_space),
        .complete_valid (complete_valid),
        .complete       (complete),
        .complete_tag   (complete_tag)
    );

    always #50 clk_in = ~clk_in;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_complete(input string name, input complete_t exp, input complete_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s expected rd=%0d value=%h actual rd=%0d value=%h",
                                     name, exp.rd, exp.value, act.rd, act.value));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    // result of one instruction by the ISA rules, operands taken in program order
    function automatic word_t model_result(input issue_req_t req, input word_t a,
                                           input word_t b);
        word_t r;
        case (req.op)
            OP_ADD:   r = a + b;
            OP_SUB:   r = a - b;
            OP_AND:   r = a & b;
            OP_OR:    r = a | b;
            OP_XOR:   r = a ^ b;
            OP_SLL:   r = a << b[4:0];
            OP_SRL:   r = a >> b[4:0];
            OP_SRA:   r = $signed(a) >>> b[4:0];
            OP_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
            OP_ADDI:  r = a + req.imm;
            OP_ANDI:  r = a & req.imm;
            OP_ORI:   r = a | req.imm;
            OP_XORI:  r = a ^ req.imm;
            OP_SLLI:  r = a << req.imm[4:0];
            OP_SRLI:  r = a >> req.imm[4:0];
            OP_SRAI:  r = $signed(a) >>> req.imm[4:0];
            OP_SLTI:  r = ($signed(a) < $signed(req.imm)) ? 32'd1 : 32'd0;
            OP_SLTIU: r = (a < req.imm) ? 32'd1 : 32'd0;
            OP_LUI:   r = req.imm;
            default:  r = req.pc + req.imm;
        endcase
        return r;
    endfunction

    task automatic add_row(input string name, input inst_op_e op, input int rd, input int rs1,
                           input int rs2, input word_t imm, input word_t pc,
                           input logic hold, input logic flush_after);
        row_t row;
        row.req.op  = op;
        row.req.rd  = reg_idx_t'(rd);
        row.req.rs1 = reg_idx_t'(rs1);
        row.req.rs2 = reg_idx_t'(rs2);
        row.req.imm = imm;
        row.req.pc  = pc;
        row.hold    = hold;
        row.flush   = flush_after;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        // one op at a time into an idle station
        add_row("lui_x1",   OP_LUI,   1, 0, 0, 32'h8765_4000, 32'h0, 0, 0);
        add_row("addi_x1",  OP_ADDI,  1, 1, 0, 32'h0000_0321, 32'h0, 0, 0);
        add_row("lui_x2",   OP_LUI,   2, 0, 0, 32'h1234_5000, 32'h0, 0, 0);
        add_row("addi_x2",  OP_ADDI,  2, 2, 0, 32'hffff_f9ab, 32'h0, 0, 0);
        add_row("auipc_x3", OP_AUIPC, 3, 0, 0, 32'h0000_2000, 32'h0000_0a40, 0, 0);
        add_row("add",      OP_ADD,   4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("sub",      OP_SUB,   4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("and",      OP_AND,   4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("or",       OP_OR,    4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("xor",      OP_XOR,   4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("sll",      OP_SLL,   4, 1, 3, 32'h0, 32'h0, 0, 0);
        add_row("srl",      OP_SRL,   4, 1, 3, 32'h0, 32'h0, 0, 0);
        add_row("sra",      OP_SRA,   4, 1, 3, 32'h0, 32'h0, 0, 0);
        add_row("slt",      OP_SLT,   4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("sltu",     OP_SLTU,  4, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("andi",     OP_ANDI,  4, 1, 0, 32'h0f0f_0ff0, 32'h0, 0, 0);
        add_row("ori",      OP_ORI,   4, 2, 0, 32'h8000_0001, 32'h0, 0, 0);
        add_row("xori",     OP_XORI,  4, 1, 0, 32'hffff_ffff, 32'h0, 0, 0);
        add_row("slli",     OP_SLLI,  4, 2, 0, 32'h0000_0004, 32'h0, 0, 0);
        add_row("srli",     OP_SRLI,  4, 1, 0, 32'h0000_0007, 32'h0, 0, 0);
        add_row("srai",     OP_SRAI,  4, 1, 0, 32'h0000_0009, 32'h0, 0, 0);
        add_row("slti",     OP_SLTI,  4, 1, 0, 32'hffff_f000, 32'h0, 0, 0);
        add_row("sltiu",    OP_SLTIU, 4, 2, 0, 32'h0000_0800, 32'h0, 0, 0);
        add_row("add_x0",   OP_ADD,   0, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("lui_x0",   OP_LUI,   0, 0, 0, 32'hdead_b000, 32'h0, 0, 0);
        // back-to-back dependents, woken by commits at random points
        add_row("chain_add",  OP_ADD,  5, 1, 2, 32'h0, 32'h0, 0, 0);
        add_row("chain_sub",  OP_SUB,  6, 5, 1, 32'h0, 32'h0, 0, 0);
        add_row("chain_xor",  OP_XOR,  7, 6, 5, 32'h0, 32'h0, 0, 0);
        add_row("chain_slli", OP_SLLI, 8, 7, 0, 32'h0000_0003, 32'h0, 0, 0);
        add_row("chain_or",   OP_OR,   9, 8, 6, 32'h0, 32'h0, 0, 0);
        add_row("chain_sltu", OP_SLTU, 10, 9, 7, 32'h0, 32'h0, 0, 0);
        add_row("chain_addi", OP_ADDI, 5, 5, 0, 32'h0000_0001, 32'h0, 0, 0);
        add_row("chain_sra",  OP_SRA,  11, 5, 3, 32'h0, 32'h0, 0, 0);
        // four dependents of a held producer fill the station
        add_row("hold_prod",  OP_ADDI, 12, 11, 0, 32'h0000_0005, 32'h0, 1, 0);
        add_row("hold_dep1",  OP_ADD,  13, 12, 1, 32'h0, 32'h0, 1, 0);
        add_row("hold_dep2",  OP_SUB,  14, 12, 2, 32'h0, 32'h0, 1, 0);
        add_row("hold_dep3",  OP_AND,  15, 12, 12, 32'h0, 32'h0, 1, 0);
        add_row("hold_dep4",  OP_XORI, 16, 12, 0, 32'h0000_0a5a, 32'h0, 1, 0);
        add_row("resume",     OP_ADD,  17, 13, 16, 32'h0, 32'h0, 0, 0);
        // x18 and x19 are renamed to tags that the flush throws away
        add_row("flush_base", OP_ADDI, 18, 0, 0, 32'h0000_0055, 32'h0, 0, 0);
        add_row("flush_prod", OP_ADD,  19, 18, 1, 32'h0, 32'h0, 1, 0);
        add_row("flush_dep",  OP_SUB,  18, 19, 2, 32'h0, 32'h0, 1, 1);
        add_row("after_x18",  OP_ADDI, 20, 18, 0, 32'h0000_0010, 32'h0, 0, 0);
        add_row("after_x19",  OP_OR,   21, 19, 18, 32'h0, 32'h0, 0, 0);
        add_row("after_add",  OP_ADD,  22, 20, 21, 32'h0, 32'h0, 0, 0);
    endtask

    // one falling edge: collect a completion, check the space level, then drive commits
    task automatic step_cycle();
        int ct;
        int slot;
        int hidx;
        @(negedge clk_in);
        cycle++;
        if (complete_valid) begin
            ct   = int'(complete_tag);
            slot = (ct - (head % NTAGS) + NTAGS) % NTAGS;
            if (slot >= count || done[ct]) begin
                report_failure($sformatf("completion carries tag %0d, which is not outstanding",
                                         ct));
            end
            check_complete(tag_name[ct], exp_res[ct], complete);
            if (exact[ct] && cycle - issue_cycle[ct] != 4) begin
                report_failure($sformatf("%s completed %0d cycles after issue instead of 4",
                                         tag_name[ct], cycle - issue_cycle[ct]));
            end
            done[ct] = 1'b1;
            uncompleted--;
        end
        check_flag("issue_space", uncompleted < STATION_DEPTH, issue_space);
        if (!issue_space) begin
            space_low_seen = 1'b1;
        end
        issue_valid  = 1'b0;
        commit_valid = 1'b0;
        flush        = 1'b0;
        hidx         = head % NTAGS;
        if (!hold_commits && count > 0 && done[hidx] && ($urandom % 4) != 0) begin
            commit_valid = 1'b1;
            commit_tag   = TAG_WIDTH'(hidx);
            commit.rd    = exp_res[hidx].rd;
            commit.value = exp_res[hidx].value;
            if (commit.rd != '0) begin
                arch_regs[commit.rd] = commit.value;
            end
            head++;
            count--;
        end
    endtask

    task automatic issue_row(input int r, input logic need_idle);
        issue_req_t req;
        int         waited;
        int         idx;
        // older tags have to drain before a hold starts, so they still commit while waiting
        hold_commits = rows[r].hold && !need_idle;
        waited       = 0;
        step_cycle();
        while (!issue_space || count >= NTAGS - 4 || (need_idle && count != 0)) begin
            if (waited == WAIT_LIMIT) begin
                report_failure($sformatf("%s could not be issued in time", row_names[r]));
            end else begin
                waited++;
                step_cycle();
            end
        end
        hold_commits = rows[r].hold;
        req     = rows[r].req;
        req.imm = req.imm ^ ($urandom & 32'h0000_0fff);
        idx     = tail % NTAGS;
        exp_res[idx].rd    = req.rd;
        exp_res[idx].value = model_result(req, spec_regs[req.rs1], spec_regs[req.rs2]);
        if (req.rd != '0) begin
            spec_regs[req.rd] = exp_res[idx].value;
        end
        done[idx]        = 1'b0;
        exact[idx]       = (count == 0);
        issue_cycle[idx] = cycle;
        tag_name[idx]    = row_names[r];
        issue_valid = 1'b1;
        issue_req   = req;
        issue_tag   = TAG_WIDTH'(idx);
        tail++;
        count++;
        uncompleted++;
        if (rows[r].flush) begin
            step_cycle();
            flush = 1'b1;
            // the speculative image falls back to what has been committed
            tail        = head;
            count       = 0;
            uncompleted = 0;
            spec_regs   = arch_regs;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(32'h88df));
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        issue_valid  = 1'b0;
        issue_req    = '0;
        issue_tag    = '0;
        commit_valid = 1'b0;
        commit       = '0;
        commit_tag   = '0;
        flush        = 1'b0;
        head         = 0;
        tail         = 0;
        count        = 0;
        uncompleted  = 0;
        cycle        = 0;
        hold_commits = 1'b0;
        space_low_seen = 1'b0;
        for (int i = 0; i < 32; i++) begin
            spec_regs[i] = '0;
            arch_regs[i] = '0;
        end
        for (int t = 0; t < NTAGS; t++) begin
            done[t]  = 1'b0;
            exact[t] = 1'b0;
        end
        build_table();

        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        // quiet after reset
        repeat (6) step_cycle();

        for (int r = 0; r < rows.size(); r++) begin
            issue_row(r, r < SINGLE_ROWS || (rows[r].hold && !rows[r - 1].hold));
        end

        hold_commits = 1'b0;
        waited       = 0;
        step_cycle();
        while (count != 0) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("outstanding tags did not drain");
            end else begin
                waited++;
                step_cycle();
            end
        end
        repeat (8) step_cycle();

        if (!space_low_seen) begin
            report_failure("issue_space never fell while commits were held");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
logic/rs_pkg.sv
logic/issue_decode.sv
logic/operand_fetch.sv
logic/station_array.sv
logic/alu_execute.sv
logic/rs_top.sv
dv/rs_asserts.sv
dv/tb_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
